// ==== Bender.yml ====
package:
  name: immPipe

sources:
  # Shared package first, everything else imports it
  - files:
      - common/thorPkg.sv
  - files:
      - hw/pipeReg.sv
      - hw/decode/fpSingleToDouble.sv
      - hw/decode/immDecoder.sv
      - hw/decode/decodeStage.sv
      - hw/immAlu.sv
      - hw/immPipeTop.sv
  - target: test
    files:
      - tb/immPipeTb.sv

// ==== common/thorPkg.sv ====
`default_nettype none

package thorPkg;

	// ==================================================
	// Widths and field positions
	// ==================================================

	localparam int InsWidth = 40;
	localparam int GroupSize = 5;
	localparam int DataWidth = 64;
	localparam int RegWidth = 6;

	// Opcode and destination register of every instruction
	localparam int OpHi = 6;
	localparam int OpLo = 0;
	localparam int RdHi = 12;
	localparam int RdLo = 7;

	// All immediate fields share their top bit, which is also the sign
	localparam int ImmHi = 34;
	localparam int Imm16Lo = 19;
	localparam int Disp14Lo = 21;
	localparam int Imm22Lo = 13;

	// A postfix carries 32 bits of immediate above its opcode byte
	localparam int PfxHi = 39;
	localparam int PfxLo = 8;

	// Exponent biases for single and double precision
	localparam int SpBias = 127;
	localparam int DpBias = 1023;

	typedef logic [InsWidth-1:0] instruction_t;

	// ==================================================
	// Opcodes handled by the immediate pipeline
	// ==================================================

	typedef enum logic [6:0] {
		OpAddi = 7'd4,
		OpCmpi = 7'd5,
		OpMuli = 7'd6,
		OpSubfi = 7'd7,
		OpAndi = 7'd8,
		OpOri = 7'd9,
		OpEori = 7'd10,
		OpSlti = 7'd11,
		OpDivi = 7'd13,
		OpRtd = 7'd19,
		OpLdb = 7'd64,
		OpLdbu = 7'd65,
		OpLdw = 7'd66,
		OpLdwu = 7'd67,
		OpLdt = 7'd68,
		OpLdtu = 7'd69,
		OpLdo = 7'd70,
		OpLda = 7'd74,
		OpCache = 7'd76,
		OpStb = 7'd80,
		OpStw = 7'd81,
		OpStt = 7'd82,
		OpSto = 7'd83,
		OpFlt2 = 7'd88,
		OpFlt3 = 7'd89,
		OpAddipc = 7'd125,
		OpPfx = 7'd126
	} opcode_t;

	// Payload held in the decode register between the two stages
	typedef struct packed {
		opcode_t op;
		logic [RegWidth-1:0] rd;
		logic [DataWidth-1:0] operand;
		logic [DataWidth-1:0] pc;
		logic [DataWidth-1:0] imm;
	} decodedOp_t;

	// Payload of the result register at the end of execute
	typedef struct packed {
		logic [RegWidth-1:0] rd;
		logic [DataWidth-1:0] value;
	} result_t;

endpackage

`default_nettype wire

// ==== hw/decode/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decode stage that registers the opcode, destination and immediate
module decodeStage import thorPkg::*; (
	input wire logic clk,
	input wire logic arstN,
	input wire logic [GroupSize*InsWidth-1:0] insGroup,
	input wire logic [DataWidth-1:0] operand,
	input wire logic [DataWidth-1:0] pc,
	input wire logic inValid,
	output logic inReady,
	output logic decValid,
	output opcode_t decOp,
	output logic [RegWidth-1:0] decRd,
	output logic [DataWidth-1:0] decOperand,
	output logic [DataWidth-1:0] decPc,
	output logic [DataWidth-1:0] decImm,
	input wire logic decReady
);

	instruction_t ins0;
	logic [DataWidth-1:0] imm;
	decodedOp_t decIn;
	decodedOp_t decOut;

	// Instruction 0 is the one being decoded
	// The rest of the group only supplies postfixes
	assign ins0 = insGroup[InsWidth-1:0];

	immDecoder uImm (
		.insGroup(insGroup),
		.imm(imm)
	);

	// ==================================================
	// Decode register
	// ==================================================

	assign decIn.op = opcode_t'(ins0[OpHi:OpLo]);
	assign decIn.rd = ins0[RdHi:RdLo];
	assign decIn.operand = operand;
	assign decIn.pc = pc;
	assign decIn.imm = imm;

	pipeReg #(
		.payload_t(decodedOp_t)
	) uDecReg (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inData(decIn),
		.inReady(inReady),
		.outValid(decValid),
		.outData(decOut),
		.outReady(decReady)
	);

	assign decOp = decOut.op;
	assign decRd = decOut.rd;
	assign decOperand = decOut.operand;
	assign decPc = decOut.pc;
	assign decImm = decOut.imm;

	// The fetch side must hold an offered group until it is taken
	aInputHold: assert property (@(posedge clk) disable iff (!arstN)
		inValid && !inReady |=> inValid && $stable(insGroup) && $stable(operand)
			&& $stable(pc));

endmodule

`default_nettype wire

// ==== hw/decode/fpSingleToDouble.sv ====
`timescale 1ns/100ps
`default_nettype none

// Widens an IEEE single precision value to double precision
module fpSingleToDouble import thorPkg::*; (
	input wire logic [31:0] single,
	output logic [63:0] double
);

	logic sign;
	logic [7:0] spExp;
	logic [22:0] spFrac;
	logic [10:0] dpExp;

	assign sign = single[31];
	assign spExp = single[30:23];
	assign spFrac = single[22:0];

	// ==================================================
	// Exponent rebias
	// ==================================================

	// Normal numbers move from a bias of 127 to a bias of 1023
	assign dpExp = 11'(spExp) + 11'(DpBias - SpBias);

	always_comb begin
		if (spExp == 8'h00) begin
			// Zero keeps its sign
			// Denormals are flushed to a signed zero as well
			double = {sign, 63'd0};
		end else if (spExp == 8'hFF) begin
			// Infinity and NaN keep the fraction so NaN payloads survive
			double = {sign, 11'h7FF, spFrac, 29'd0};
		end else begin
			// The fraction lands in the top of the 52 bit mantissa
			double = {sign, dpExp, spFrac, 29'd0};
		end
	end

endmodule

`default_nettype wire

// ==== hw/decode/immDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

// Builds the 64 bit immediate of instruction 0 from a fetch group
module immDecoder import thorPkg::*; (
	input wire instruction_t [GroupSize-1:0] insGroup,
	output logic [DataWidth-1:0] imm
);

	opcode_t op;
	logic pfx1;
	logic pfx2;
	logic [31:0] pfxLo;
	logic [31:0] pfxHi;
	logic [DataWidth-1:0] fltImm;

	assign op = opcode_t'(insGroup[0][OpHi:OpLo]);

	// Postfixes only count when they follow each other directly
	assign pfx1 = opcode_t'(insGroup[1][OpHi:OpLo]) == OpPfx;
	assign pfx2 = pfx1 && (opcode_t'(insGroup[2][OpHi:OpLo]) == OpPfx);
	assign pfxLo = insGroup[1][PfxHi:PfxLo];
	assign pfxHi = insGroup[2][PfxHi:PfxLo];

	// The float opcodes read a single precision constant from the postfix
	fpSingleToDouble uCvt (
		.single(pfxLo),
		.double(fltImm)
	);

	always_comb begin
		imm = '0;

		// ==================================================
		// Base field of instruction 0
		// ==================================================

		case (op)
			OpAddi, OpCmpi, OpSubfi, OpSlti:
				imm = {{48{insGroup[0][ImmHi]}}, insGroup[0][ImmHi:Imm16Lo]};
			// AND keeps the upper bits of the operand by filling with ones
			OpAndi:
				imm = {48'hFFFF_FFFF_FFFF, insGroup[0][ImmHi:Imm16Lo]};
			OpOri, OpEori:
				imm = {48'h0, insGroup[0][ImmHi:Imm16Lo]};
			OpLdb, OpLdbu, OpLdw, OpLdwu, OpLdt, OpLdtu, OpLdo, OpLda,
			OpStb, OpStw, OpStt, OpSto:
				imm = {{50{insGroup[0][ImmHi]}}, insGroup[0][ImmHi:Disp14Lo]};
			OpAddipc:
				imm = {{42{insGroup[0][ImmHi]}}, insGroup[0][ImmHi:Imm22Lo]};
			default:
				imm = '0;
		endcase

		// ==================================================
		// Postfix override
		// ==================================================

		case (op)
			OpAddi, OpCmpi, OpSubfi, OpSlti, OpAndi, OpOri, OpEori,
			OpLdb, OpLdbu, OpLdw, OpLdwu, OpLdt, OpLdtu, OpLdo, OpLda,
			OpStb, OpStw, OpStt, OpSto, OpAddipc, OpFlt2, OpFlt3: begin
				// The base field is ignored once a postfix is present
				if (pfx1) begin
					imm = {{32{pfxLo[31]}}, pfxLo};
				end
				if (pfx2) begin
					imm[63:32] = pfxHi;
				end
			end
			// Multiply, divide, return and cache are left at zero here
			default:
				imm = '0;
		endcase

		// A single postfix on a float opcode holds a single precision value
		if ((op == OpFlt2 || op == OpFlt3) && pfx1 && !pfx2) begin
			imm = fltImm;
		end
	end

endmodule

`default_nettype wire

// ==== hw/immAlu.sv ====
`timescale 1ns/100ps
`default_nettype none

// Execute stage for the immediate operations
module immAlu import thorPkg::*; (
	input wire logic clk,
	input wire logic arstN,
	input wire logic decValid,
	input wire opcode_t decOp,
	input wire logic [RegWidth-1:0] decRd,
	input wire logic [DataWidth-1:0] decOperand,
	input wire logic [DataWidth-1:0] decPc,
	input wire logic [DataWidth-1:0] decImm,
	output logic decReady,
	output logic resValid,
	output logic [RegWidth-1:0] resRd,
	output logic [DataWidth-1:0] resValue,
	input wire logic resReady
);

	logic [DataWidth-1:0] sum;
	logic lessThan;
	logic [DataWidth-1:0] value;
	result_t resIn;
	result_t resOut;

	// Adds and address generation share one adder
	assign sum = decOperand + decImm;
	assign lessThan = $signed(decOperand) < $signed(decImm);

	// ==================================================
	// Operation select
	// ==================================================

	always_comb begin
		case (decOp)
			OpAddi,
			OpLdb, OpLdbu, OpLdw, OpLdwu, OpLdt, OpLdtu, OpLdo, OpLda,
			OpStb, OpStw, OpStt, OpSto:
				value = sum;
			// Subtract from reverses the operands
			OpSubfi:
				value = decImm - decOperand;
			OpAndi:
				value = decOperand & decImm;
			OpOri:
				value = decOperand | decImm;
			OpEori:
				value = decOperand ^ decImm;
			OpSlti:
				value = {63'd0, lessThan};
			OpCmpi: begin
				// Minus one for less, zero for equal, one for greater
				if (lessThan) begin
					value = '1;
				end else if (decOperand == decImm) begin
					value = '0;
				end else begin
					value = 64'd1;
				end
			end
			OpAddipc:
				value = decPc + decImm;
			// Float immediates were already converted during decode
			OpFlt2, OpFlt3:
				value = decImm;
			default:
				value = '0;
		endcase
	end

	// ==================================================
	// Result register
	// ==================================================

	assign resIn.rd = decRd;
	assign resIn.value = value;

	pipeReg #(
		.payload_t(result_t)
	) uResReg (
		.clk(clk),
		.arstN(arstN),
		.inValid(decValid),
		.inData(resIn),
		.inReady(decReady),
		.outValid(resValid),
		.outData(resOut),
		.outReady(resReady)
	);

	assign resRd = resOut.rd;
	assign resValue = resOut.value;

endmodule

`default_nettype wire

// ==== hw/immPipeTop.sv ====
`timescale 1ns/100ps
`default_nettype none

// Two stage immediate pipeline with decode feeding execute
module immPipeTop import thorPkg::*; (
	input wire logic clk,
	input wire logic arstN,
	input wire logic [GroupSize*InsWidth-1:0] insGroup,
	input wire logic [DataWidth-1:0] operand,
	input wire logic [DataWidth-1:0] pc,
	input wire logic inValid,
	output logic inReady,
	output logic resValid,
	output logic [RegWidth-1:0] resRd,
	output logic [DataWidth-1:0] resValue,
	input wire logic resReady
);

	// Handshake and payload between the stages
	logic decValid;
	logic decReady;
	opcode_t decOp;
	logic [RegWidth-1:0] decRd;
	logic [DataWidth-1:0] decOperand;
	logic [DataWidth-1:0] decPc;
	logic [DataWidth-1:0] decImm;

	decodeStage uDecode (
		.clk(clk),
		.arstN(arstN),
		.insGroup(insGroup),
		.operand(operand),
		.pc(pc),
		.inValid(inValid),
		.inReady(inReady),
		.decValid(decValid),
		.decOp(decOp),
		.decRd(decRd),
		.decOperand(decOperand),
		.decPc(decPc),
		.decImm(decImm),
		.decReady(decReady)
	);

	immAlu uExec (
		.clk(clk),
		.arstN(arstN),
		.decValid(decValid),
		.decOp(decOp),
		.decRd(decRd),
		.decOperand(decOperand),
		.decPc(decPc),
		.decImm(decImm),
		.decReady(decReady),
		.resValid(resValid),
		.resRd(resRd),
		.resValue(resValue),
		.resReady(resReady)
	);

endmodule

`default_nettype wire

// ==== hw/pipeReg.sv ====
`timescale 1ns/100ps
`default_nettype none

// Single entry register with a valid/ready handshake on both sides
module pipeReg #(
	parameter type payload_t = logic
) (
	input wire logic clk,
	input wire logic arstN,
	input wire logic inValid,
	input wire payload_t inData,
	output logic inReady,
	output logic outValid,
	output payload_t outData,
	input wire logic outReady
);

	logic full;
	payload_t data;

	// Accept new data when empty or when the held entry leaves this cycle
	assign inReady = !full || outReady;
	assign outValid = full;
	assign outData = data;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			full <= 1'b0;
		end else if (inValid && inReady) begin
			full <= 1'b1;
		end else if (outReady) begin
			// Drained downstream with nothing arriving
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			data <= inData;
		end
	end

	// A stalled entry stays put until the consumer takes it
	aStallHold: assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(outData));

	aValidKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(outValid));

endmodule

`default_nettype wire

// ==== project.f ====
common/thorPkg.sv
hw/pipeReg.sv
hw/decode/fpSingleToDouble.sv
hw/decode/immDecoder.sv
hw/decode/decodeStage.sv
hw/immAlu.sv
hw/immPipeTop.sv
tb/immPipeTb.sv

// ==== tb/immPipeTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module immPipeTb import thorPkg::*; ();

	localparam int MaxRows = 32;
	localparam int ResetCycles = 5;

	logic clk;
	logic arstN;
	logic [GroupSize*InsWidth-1:0] insGroup;
	logic [DataWidth-1:0] operand;
	logic [DataWidth-1:0] pc;
	logic inValid;
	logic inReady;
	logic resValid;
	logic [RegWidth-1:0] resRd;
	logic [DataWidth-1:0] resValue;
	logic resReady;

	// Stimulus table with one fetch group and its expected result per row
	logic [GroupSize*InsWidth-1:0] rowGroup [0:MaxRows-1];
	logic [RegWidth-1:0] rowRd [0:MaxRows-1];
	logic [DataWidth-1:0] rowOperand [0:MaxRows-1];
	logic [DataWidth-1:0] rowPc [0:MaxRows-1];
	logic [DataWidth-1:0] rowExp [0:MaxRows-1];
	int numRows;

	// Rows in flight and the cycle in which each was accepted
	// The cycle is -1 when latency is not checked
	int expIdx [$];
	int expCycle [$];
	int monIdx;
	int monCycle;
	int checked;
	int cycle;
	integer seed;
	bit stallMode;
	bit latencyCheck;

	immPipeTop uut (
		.clk(clk),
		.arstN(arstN),
		.insGroup(insGroup),
		.operand(operand),
		.pc(pc),
		.inValid(inValid),
		.inReady(inReady),
		.resValid(resValid),
		.resRd(resRd),
		.resValue(resValue),
		.resReady(resReady)
	);

	always #5 clk = ~clk;

	task automatic reportFailure();
		$display("test failed");
		$fatal(1, "Simulation stopped after an error");
	endtask

	// Places the field at its low bit and appends up to two postfixes
	task automatic addRow(input opcode_t op, input logic [5:0] rd, input int lo,
		input logic [21:0] field, input int nPfx, input logic [31:0] pfxLo,
		input logic [31:0] pfxHi, input logic [63:0] opnd, input logic [63:0] pcVal,
		input logic [63:0] expVal);
		instruction_t [GroupSize-1:0] grp;
		int k;
		// Filler slots look like an ordinary add so they never count as postfixes
		for (k = 0; k < GroupSize; k++) begin
			grp[k] = {32'hA5C3_0F96, 1'b0, 7'(OpAddi)};
		end
		grp[0] = 40'(op) | (40'(rd) << RdLo) | (40'(field) << lo);
		if (nPfx > 0) begin
			grp[1] = {pfxLo, 1'b0, 7'(OpPfx)};
		end
		if (nPfx > 1) begin
			grp[2] = {pfxHi, 1'b0, 7'(OpPfx)};
		end
		rowGroup[numRows] = grp;
		rowRd[numRows] = rd;
		rowOperand[numRows] = opnd;
		rowPc[numRows] = pcVal;
		rowExp[numRows] = expVal;
		numRows++;
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================

	task automatic buildTable();
		numRows = 0;
		// Signed 16 bit fields
		addRow(OpAddi, 1, Imm16Lo, 'hFFF0, 0, 0, 0, 64'd100, 0, 64'd84);
		addRow(OpAddi, 2, Imm16Lo, 'h1234, 0, 0, 0, 64'h1000, 0, 64'h2234);
		addRow(OpCmpi, 3, Imm16Lo, 'hFFFF, 0, 0, 0, -64'sd5, 0, '1);
		addRow(OpCmpi, 4, Imm16Lo, 'h0010, 0, 0, 0, 64'd16, 0, 64'd0);
		addRow(OpCmpi, 5, Imm16Lo, 'h8000, 0, 0, 0, 64'd0, 0, 64'd1);
		addRow(OpSubfi, 6, Imm16Lo, 'hFFFE, 0, 0, 0, 64'd3, 0, -64'sd5);
		addRow(OpSlti, 7, Imm16Lo, 'hFF00, 0, 0, 0, -64'sd300, 0, 64'd1);
		addRow(OpSlti, 8, Imm16Lo, 'h0005, 0, 0, 0, 64'd7, 0, 64'd0);
		// AND fills the upper bits with ones and OR/EOR fill them with zeros
		addRow(OpAndi, 9, Imm16Lo, 'h00F0, 0, 0, 0, 64'h1234_5678_9ABC_DEF1, 0,
			64'h1234_5678_9ABC_00F0);
		addRow(OpOri, 10, Imm16Lo, 'h8001, 0, 0, 0, 64'hFFFF_0000_0000_0000, 0,
			64'hFFFF_0000_0000_8001);
		addRow(OpEori, 11, Imm16Lo, 'hFFFF, 0, 0, 0, 64'h0F0F, 0, 64'hF0F0);
		// 14 bit displacements and the 22 bit PC offset
		addRow(OpLdb, 12, Disp14Lo, 'h3FFF, 0, 0, 0, 64'h1000, 0, 64'h0FFF);
		addRow(OpLdo, 13, Disp14Lo, 'h0100, 0, 0, 0, 64'h2000, 0, 64'h2100);
		addRow(OpSto, 14, Disp14Lo, 'h2000, 0, 0, 0, 64'h1_0000, 0, 64'hE000);
		addRow(OpAddipc, 15, Imm22Lo, 'h3FFFFC, 0, 0, 0, 64'h77, 64'h4000, 64'h3FFC);
		addRow(OpAddipc, 16, Imm22Lo, 'h0ABCDE, 0, 0, 0, 64'h77, 64'h1_0000_0000,
			64'h1_000A_BCDE);
		// Postfixes replace the base field
		addRow(OpAddi, 17, Imm16Lo, 'h1234, 1, 32'h8000_0000, 0, 64'd5, 0,
			64'hFFFF_FFFF_8000_0005);
		addRow(OpOri, 18, Imm16Lo, 'h1234, 2, 32'hDEAD_BEEF, 32'h0123_4567, 64'h10, 0,
			64'h0123_4567_DEAD_BEFF);
		// Single precision constants widened to double
		addRow(OpFlt2, 19, Imm16Lo, 0, 1, 32'h3F80_0000, 0, 64'h55, 0, 64'h3FF0_0000_0000_0000);
		addRow(OpFlt3, 20, Imm16Lo, 0, 1, 32'hC020_0000, 0, 64'h55, 0, 64'hC004_0000_0000_0000);
		addRow(OpFlt2, 21, Imm16Lo, 0, 1, 32'h0000_0000, 0, 64'h55, 0, 64'd0);
		addRow(OpFlt2, 22, Imm16Lo, 0, 1, 32'h7F80_0000, 0, 64'h55, 0, 64'h7FF0_0000_0000_0000);
		addRow(OpFlt3, 23, Imm16Lo, 0, 1, 32'h0040_0000, 0, 64'h55, 0, 64'd0);
		addRow(OpFlt2, 24, Imm16Lo, 0, 2, 32'h89AB_CDEF, 32'h4009_21FB, 64'h55, 0,
			64'h4009_21FB_89AB_CDEF);
		// Opcodes outside this slice give zero
		addRow(OpMuli, 25, Imm16Lo, 'h0005, 0, 0, 0, 64'd7, 0, 64'd0);
		addRow(OpDivi, 26, Imm16Lo, 'h0003, 0, 0, 0, 64'd9, 0, 64'd0);
		addRow(OpRtd, 27, Imm16Lo, 'h0010, 0, 0, 0, 64'd1, 0, 64'd0);
		addRow(OpCache, 28, Disp14Lo, 'h0040, 0, 0, 0, 64'h800, 0, 64'd0);
	endtask

	// Called 1 ns after a rising edge and returns 1 ns after the accepting edge
	task automatic sendRow(input int idx, input bit gaps);
		bit taken;
		int tries;
		if (gaps) begin
			while (($random(seed) & 3) == 0) begin
				inValid = 1'b0;
				@(posedge clk);
				#1;
			end
		end
		insGroup = rowGroup[idx];
		operand = rowOperand[idx];
		pc = rowPc[idx];
		inValid = 1'b1;
		taken = 1'b0;
		tries = 0;
		// inReady is sampled at the falling edge where it has settled
		while (!taken) begin
			@(negedge clk);
			taken = inReady;
			tries++;
			@(posedge clk);
			#1;
		end
		// With the output always ready every row goes in on its first offer
		assert (gaps || tries == 1)
			else begin
				$display("Row %0d waited %0d cycles for inReady in the back to back pass",
					idx, tries);
				reportFailure();
			end
		expIdx.push_back(idx);
		expCycle.push_back(latencyCheck ? cycle : -1);
		inValid = 1'b0;
	endtask

	task automatic drain();
		while (expIdx.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	// ==================================================
	// Output side, stalls, monitor and cycle limit
	// ==================================================

	always @(posedge clk) begin
		#1;
		if (stallMode) begin
			resReady = ($random(seed) & 3) != 0;
		end else begin
			resReady = 1'b1;
		end
	end

	// A transfer seen at the falling edge completes at the next rising edge
	always @(negedge clk) begin
		if (arstN && resValid && resReady) begin
			if (expIdx.size() == 0) begin
				$display("A result appeared at %0t with no row pending", $time);
				reportFailure();
			end else begin
				monIdx = expIdx.pop_front();
				monCycle = expCycle.pop_front();
				assert (resRd == rowRd[monIdx])
					else begin
						$display("FAILED at %0t: resRd expected %0d, actual %0d",
							$time, rowRd[monIdx], resRd);
						reportFailure();
					end
				assert (resValue == rowExp[monIdx])
					else begin
						$display("FAILED at %0t: resValue expected %h, actual %h",
							$time, rowExp[monIdx], resValue);
						reportFailure();
					end
				assert (monCycle < 0 || cycle + 1 == monCycle + 2)
					else begin
						$display("Row %0d was taken at edge %0d, two edges after %0d expected",
							monIdx, cycle + 1, monCycle);
						reportFailure();
					end
				checked++;
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= 20 * 2 * numRows + ResetCycles) begin
			$display("The run exceeded its cycle limit of %0d cycles", cycle);
			reportFailure();
		end
	end

	initial begin
		seed = 82;
		clk = 1'b0;
		arstN = 1'b0;
		insGroup = '0;
		operand = '0;
		pc = '0;
		inValid = 1'b0;
		resReady = 1'b0;
		cycle = 0;
		checked = 0;
		stallMode = 1'b1;
		latencyCheck = 1'b0;
		buildTable();
		repeat (ResetCycles) @(posedge clk);
		#1;
		arstN = 1'b1;

		// First pass with random input gaps and output stalls
		for (int i = 0; i < numRows; i++) begin
			sendRow(i, 1'b1);
		end
		drain();

		// Second pass back to back with the output always ready
		stallMode = 1'b0;
		latencyCheck = 1'b1;
		@(posedge clk);
		#1;
		for (int i = 0; i < numRows; i++) begin
			sendRow(i, 1'b0);
		end
		drain();
		repeat (3) @(posedge clk);

		if (checked == 2 * numRows) begin
			$display("test passed");
			$finish;
		end else begin
			$display("Only %0d of %0d results were checked", checked, 2 * numRows);
			reportFailure();
		end
	end

endmodule

`default_nettype wire
